// File: all.f
include/lc3b_mem_pkg.sv
include/lc3b_perf_pkg.sv
hdl/perf_bus_if.sv
hdl/perf_counter.sv
hdl/mem_access_unit.sv
hdl/load_return.sv
hdl/lc3b_mem_stage.sv
verification/tb_lc3b_mem_stage.sv

// File: hdl/lc3b_mem_stage.sv
`timescale 1ns/1ps

module lc3b_mem_stage (
    input  logic                                   clk,
    input  logic                                   i_rst_n,

    // Operation from the pipeline
    input  logic                                   i_op_valid,
    input  lc3b_mem_pkg::mem_op_t                  i_op,
    input  lc3b_mem_pkg::lc3b_word                 i_addr,
    input  lc3b_mem_pkg::lc3b_word                 i_wdata,
    output logic                                   o_stall_pipe,
    output logic                                   o_ld_valid,
    output lc3b_mem_pkg::lc3b_word                 o_ld_data,

    // Data memory port
    input  logic                                   i_d_mem_resp,
    input  lc3b_mem_pkg::lc3b_word                 i_d_mem_rdata,
    output lc3b_mem_pkg::lc3b_word                 o_d_mem_address,
    output lc3b_mem_pkg::lc3b_word                 o_d_mem_wdata,
    output logic                                   o_d_mem_read,
    output logic                                   o_d_mem_write,
    output lc3b_mem_pkg::lc3b_mem_wmask            o_d_mem_byte_enable,

    // Counter increment events
    input  logic [lc3b_perf_pkg::NUM_COUNTERS-1:0] i_event
);
    import lc3b_perf_pkg::*;

    perf_bus_if perf_bus ();

    mem_access_unit u_access (
        .clk,
        .i_rst_n,
        .i_op_valid,
        .i_op,
        .i_addr,
        .i_wdata,
        .i_d_mem_resp,
        .o_d_mem_address,
        .o_d_mem_wdata,
        .o_d_mem_read,
        .o_d_mem_write,
        .o_d_mem_byte_enable,
        .o_stall_pipe,
        .bus             (perf_bus)
    );

    // One counter per event, each on its own clear bit and count slot
    for (genvar k = 0; k < NUM_COUNTERS; k++) begin : g_counter
        perf_counter u_counter (
            .clk,
            .i_rst_n,
            .i_inc   (i_event[k]),
            .i_clear (perf_bus.clear[k]),
            .o_count (perf_bus.count[k])
        );
    end

    load_return u_return (
        .clk,
        .i_rst_n,
        .i_d_mem_rdata,
        .o_ld_valid,
        .o_ld_data,
        .bus           (perf_bus)
    );

endmodule

// File: hdl/load_return.sv
`timescale 1ns/1ps

module load_return (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  lc3b_mem_pkg::lc3b_word i_d_mem_rdata,
    output logic                   o_ld_valid,
    output lc3b_mem_pkg::lc3b_word o_ld_data,
    perf_bus_if.drain              bus
);
    import lc3b_mem_pkg::*;
    import lc3b_perf_pkg::*;

    lc3b_word counter_value;
    lc3b_word raw_data;
    lc3b_word ret_data;

    // Unpopulated slots read as zero
    always_comb begin
        counter_value = '0;
        if (int'(bus.ld_index) < NUM_COUNTERS) begin
            counter_value = bus.count[bus.ld_index];
        end
    end

    assign raw_data = bus.ld_from_counter ? counter_value : i_d_mem_rdata;

    // LDB returns one byte, zero-extended
    always_comb begin
        ret_data = raw_data;
        if (bus.ld_byte) begin
            if (bus.ld_hi) begin
                ret_data = {8'h00, raw_data[15:8]};
            end else begin
                ret_data = {8'h00, raw_data[7:0]};
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ld_valid <= 1'b0;
        end else begin
            o_ld_valid <= bus.ld_req;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.ld_req) begin
            o_ld_data <= ret_data;
        end
    end

endmodule

// File: hdl/mem_access_unit.sv
`timescale 1ns/1ps

module mem_access_unit (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_op_valid,
    input  lc3b_mem_pkg::mem_op_t       i_op,
    input  lc3b_mem_pkg::lc3b_word      i_addr,
    input  lc3b_mem_pkg::lc3b_word      i_wdata,
    input  logic                        i_d_mem_resp,
    output lc3b_mem_pkg::lc3b_word      o_d_mem_address,
    output lc3b_mem_pkg::lc3b_word      o_d_mem_wdata,
    output logic                        o_d_mem_read,
    output logic                        o_d_mem_write,
    output lc3b_mem_pkg::lc3b_mem_wmask o_d_mem_byte_enable,
    output logic                        o_stall_pipe,
    perf_bus_if.access                  bus
);
    import lc3b_mem_pkg::*;
    import lc3b_perf_pkg::*;

    logic          accept;
    logic          in_window;
    logic          win_accept;
    logic          mem_accept;
    logic          op_store;
    logic          op_byte;
    logic          req_byte;
    lc3b_word      slot_offset;
    perf_index_t   slot;
    lc3b_word      lane_wdata;
    lc3b_mem_wmask lane_mask;

    // New operations only while no memory request is open
    assign accept = i_op_valid && !o_stall_pipe;

    assign op_store = (i_op == OP_STR) || (i_op == OP_STB);
    assign op_byte  = (i_op == OP_LDB) || (i_op == OP_STB);

    // Counter window decode, bit 0 only selects the lane
    assign in_window   = (i_addr >= PERF_BASE) && (i_addr <= PERF_LAST);
    assign slot_offset = i_addr - PERF_BASE;
    assign slot        = perf_index_t'(slot_offset >> 1);

    assign win_accept = accept && in_window;
    assign mem_accept = accept && !in_window;

    assign o_stall_pipe = o_d_mem_read || o_d_mem_write;

    // Clear pulse for a store into a populated slot
    always_comb begin
        for (int k = 0; k < NUM_COUNTERS; k++) begin
            bus.clear[k] = win_accept && op_store && (slot == perf_index_t'(k));
        end
    end

    // Byte store goes to the lane picked by address bit 0
    always_comb begin
        lane_wdata = i_wdata;
        lane_mask  = MASK_WORD;
        if (i_op == OP_STB) begin
            if (i_addr[0]) begin
                lane_wdata = {i_wdata[7:0], 8'h00};
                lane_mask  = MASK_HI;
            end else begin
                lane_wdata = {8'h00, i_wdata[7:0]};
                lane_mask  = MASK_LO;
            end
        end
    end

    // Request level, held until the response edge
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_d_mem_read  <= 1'b0;
            o_d_mem_write <= 1'b0;
        end else if (mem_accept) begin
            o_d_mem_read  <= !op_store;
            o_d_mem_write <= op_store;
        end else if (i_d_mem_resp) begin
            o_d_mem_read  <= 1'b0;
            o_d_mem_write <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_accept) begin
            o_d_mem_address     <= i_addr;
            o_d_mem_wdata       <= lane_wdata;
            o_d_mem_byte_enable <= lane_mask;
            req_byte            <= op_byte;
        end
    end

    // Load completion: response of an open read, or a window load on acceptance
    always_comb begin
        if (o_d_mem_read) begin
            bus.ld_req          = i_d_mem_resp;
            bus.ld_from_counter = 1'b0;
            bus.ld_index        = '0;
            bus.ld_byte         = req_byte;
            bus.ld_hi           = o_d_mem_address[0];
        end else begin
            bus.ld_req          = win_accept && !op_store;
            bus.ld_from_counter = 1'b1;
            bus.ld_index        = slot;
            bus.ld_byte         = op_byte;
            bus.ld_hi           = i_addr[0];
        end
    end

endmodule

// File: hdl/perf_bus_if.sv
`timescale 1ns/1ps

interface perf_bus_if;
    import lc3b_mem_pkg::*;
    import lc3b_perf_pkg::*;

    // Per-counter clear and the live counter values
    logic [NUM_COUNTERS-1:0] clear;
    lc3b_word                count [NUM_COUNTERS];

    // Load completion, qualified by the fields below
    logic        ld_req;
    logic        ld_from_counter;
    perf_index_t ld_index;
    logic        ld_byte;
    logic        ld_hi;

    modport access (
        output clear,
        output ld_req,
        output ld_from_counter,
        output ld_index,
        output ld_byte,
        output ld_hi
    );

    modport drain (
        input count,
        input ld_req,
        input ld_from_counter,
        input ld_index,
        input ld_byte,
        input ld_hi
    );

endinterface

// File: hdl/perf_counter.sv
`timescale 1ns/1ps

module perf_counter (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_inc,
    input  logic                   i_clear,
    output lc3b_mem_pkg::lc3b_word o_count
);

    // Clear beats an event on the same edge and the count wraps at 16 bits
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_clear) begin
            o_count <= '0;
        end else if (i_inc) begin
            o_count <= o_count + 16'd1;
        end
    end

endmodule

// File: include/lc3b_mem_pkg.sv
package lc3b_mem_pkg;

    // Data and address word of the LC-3b
    typedef logic [15:0] lc3b_word;

    // Byte enable, bit 0 is the low byte lane
    typedef logic [1:0] lc3b_mem_wmask;

    // Memory operations handled by the stage
    typedef enum logic [1:0] {
        OP_LDR = 2'b00,
        OP_LDB = 2'b01,
        OP_STR = 2'b10,
        OP_STB = 2'b11
    } mem_op_t;

    // Lane masks
    localparam lc3b_mem_wmask MASK_WORD = 2'b11;
    localparam lc3b_mem_wmask MASK_LO   = 2'b01;
    localparam lc3b_mem_wmask MASK_HI   = 2'b10;

endpackage

// File: include/lc3b_perf_pkg.sv
package lc3b_perf_pkg;

    // Counter order: L2 hit, L2 miss, D-L1 hit, D-L1 miss, I-L1 hit, I-L1 miss,
    // branch predict, branch mispredict, stall
    localparam int NUM_COUNTERS = 9;

    // Window of word slots, one counter per even address
    localparam lc3b_mem_pkg::lc3b_word PERF_BASE  = 16'hFF00;
    localparam int                     PERF_SLOTS = 16;
    localparam lc3b_mem_pkg::lc3b_word PERF_LAST  = PERF_BASE + 16'(2 * PERF_SLOTS - 1);

    // Slot number inside the window
    typedef logic [3:0] perf_index_t;

endpackage

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing -f all.f --top-module tb_lc3b_mem_stage -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "^Test passed$" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: verification/tb_lc3b_mem_stage.sv
`timescale 1ns/1ps

module tb_lc3b_mem_stage;
    import lc3b_mem_pkg::*;
    import lc3b_perf_pkg::*;

    localparam int WAIT_LIMIT = 8;

    logic                        clk;
    logic                        i_rst_n;
    logic                        i_op_valid;
    mem_op_t                     i_op;
    lc3b_word                    i_addr;
    lc3b_word                    i_wdata;
    logic                        i_d_mem_resp;
    lc3b_word                    i_d_mem_rdata;
    logic [NUM_COUNTERS-1:0]     i_event;
    logic                        o_stall_pipe;
    logic                        o_ld_valid;
    lc3b_word                    o_ld_data;
    lc3b_word                    o_d_mem_address;
    lc3b_word                    o_d_mem_wdata;
    logic                        o_d_mem_read;
    logic                        o_d_mem_write;
    lc3b_mem_wmask               o_d_mem_byte_enable;

    // Reference counter values and data memory words
    lc3b_word cnt_model [NUM_COUNTERS];
    lc3b_word mem_model [32768];
    integer   seed = 32'ha0c;
    int       check_count = 0;
    int       err_count = 0;

    lc3b_mem_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog for the whole run
    initial begin
        repeat (20000) @(posedge clk);
        $display("Simulation timed out after 20000 cycles");
        $display("Test failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare_word(input string name, input lc3b_word got, input lc3b_word exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // LDB keeps the zero-extended byte picked by address bit 0
    function automatic lc3b_word pick_lane(input lc3b_word w, input logic is_byte,
                                           input logic hi);
        if (!is_byte) begin
            return w;
        end
        return hi ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
    endfunction

    // Events are sampled at the next edge, so the model moves ahead here
    task automatic apply_events(input logic [NUM_COUNTERS-1:0] ev, input logic clr,
                                input int idx);
        int k;
        i_event = ev;
        for (k = 0; k < NUM_COUNTERS; k++) begin
            if (clr && idx == k) begin
                cnt_model[k] = '0;
            end else if (ev[k]) begin
                cnt_model[k] = cnt_model[k] + 16'd1;
            end
        end
    endtask

    task automatic run_events(input int cycles);
        int       n;
        logic [31:0] r;
        for (n = 0; n < cycles; n++) begin
            r = $random(seed);
            apply_events(r[NUM_COUNTERS-1:0], 1'b0, 0);
            next_cycle();
        end
        i_event = '0;
    endtask

    task automatic wait_request(output logic seen);
        int cycles;
        cycles = 0;
        while (!(o_d_mem_read || o_d_mem_write) && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        seen = o_d_mem_read || o_d_mem_write;
        check_count++;
        if (!seen) begin
            err_count++;
            $display("Memory request did not rise within %0d cycles at %0t", WAIT_LIMIT, $time);
        end else if (cycles != 0) begin
            err_count++;
            $display("Memory request rose %0d cycles late at %0t", cycles, $time);
        end
    endtask

    task automatic wait_load_valid(output logic seen);
        int cycles;
        cycles = 0;
        while (!o_ld_valid && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        seen = o_ld_valid;
        check_count++;
        if (!seen) begin
            err_count++;
            $display("No load valid pulse within %0d cycles at %0t", WAIT_LIMIT, $time);
        end else if (cycles != 0) begin
            err_count++;
            $display("Load valid came %0d cycles late at %0t", cycles, $time);
        end
    endtask

    // One operation outside the window answered after 0 to 3 cycles
    task automatic mem_op(input mem_op_t op, input lc3b_word addr, input lc3b_word wdata);
        logic          is_store;
        logic          is_byte;
        logic          seen;
        lc3b_mem_wmask exp_mask;
        lc3b_word      rdata;
        int            delay;
        int            i;
        is_store = (op == OP_STR) || (op == OP_STB);
        is_byte  = (op == OP_LDB) || (op == OP_STB);
        exp_mask = MASK_WORD;
        if (op == OP_STB) begin
            exp_mask = addr[0] ? MASK_HI : MASK_LO;
        end
        rdata = mem_model[addr[15:1]];
        delay = $random(seed) & 3;
        i_op_valid = 1'b1;
        i_op       = op;
        i_addr     = addr;
        i_wdata    = wdata;
        next_cycle();
        i_op_valid = 1'b0;
        wait_request(seen);
        if (seen) begin
            for (i = 0; i <= delay; i++) begin
                compare_bit("o_d_mem_read", o_d_mem_read, !is_store);
                compare_bit("o_d_mem_write", o_d_mem_write, is_store);
                compare_bit("o_stall_pipe", o_stall_pipe, 1'b1);
                compare_word("o_d_mem_address", o_d_mem_address, addr);
                compare_word("o_d_mem_byte_enable", {14'd0, o_d_mem_byte_enable},
                             {14'd0, exp_mask});
                if (op == OP_STR) begin
                    compare_word("o_d_mem_wdata", o_d_mem_wdata, wdata);
                end else if (op == OP_STB && addr[0]) begin
                    compare_word("o_d_mem_wdata[15:8]", {8'h00, o_d_mem_wdata[15:8]},
                                 {8'h00, wdata[7:0]});
                end else if (op == OP_STB) begin
                    compare_word("o_d_mem_wdata[7:0]", {8'h00, o_d_mem_wdata[7:0]},
                                 {8'h00, wdata[7:0]});
                end
                if (i == delay) begin
                    i_d_mem_resp  = 1'b1;
                    i_d_mem_rdata = rdata;
                end
                next_cycle();
            end
            i_d_mem_resp  = 1'b0;
            i_d_mem_rdata = '0;
            compare_bit("o_d_mem_read", o_d_mem_read, 1'b0);
            compare_bit("o_d_mem_write", o_d_mem_write, 1'b0);
            compare_bit("o_stall_pipe", o_stall_pipe, 1'b0);
            if (!is_store) begin
                wait_load_valid(seen);
                if (seen) begin
                    compare_word("o_ld_data", o_ld_data, pick_lane(rdata, is_byte, addr[0]));
                end
                next_cycle();
            end
            compare_bit("o_ld_valid", o_ld_valid, 1'b0);
        end
        if (op == OP_STR) begin
            mem_model[addr[15:1]] = wdata;
        end else if (op == OP_STB && addr[0]) begin
            mem_model[addr[15:1]][15:8] = wdata[7:0];
        end else if (op == OP_STB) begin
            mem_model[addr[15:1]][7:0] = wdata[7:0];
        end
    endtask

    // Counter window access with events driven on the acceptance edge
    task automatic window_op(input mem_op_t op, input int slot, input logic hi,
                             input lc3b_word wdata, input logic [NUM_COUNTERS-1:0] ev);
        logic     is_store;
        logic     seen;
        lc3b_word exp_raw;
        is_store = (op == OP_STR) || (op == OP_STB);
        exp_raw  = (slot < NUM_COUNTERS) ? cnt_model[slot] : 16'h0000;
        i_op_valid = 1'b1;
        i_op       = op;
        i_addr     = PERF_BASE + lc3b_word'(2 * slot) + {15'd0, hi};
        i_wdata    = wdata;
        apply_events(ev, is_store && slot < NUM_COUNTERS, slot);
        next_cycle();
        i_op_valid = 1'b0;
        i_event    = '0;
        compare_bit("o_d_mem_read", o_d_mem_read, 1'b0);
        compare_bit("o_d_mem_write", o_d_mem_write, 1'b0);
        compare_bit("o_stall_pipe", o_stall_pipe, 1'b0);
        if (!is_store) begin
            wait_load_valid(seen);
            if (seen) begin
                compare_word("o_ld_data", o_ld_data, pick_lane(exp_raw, op == OP_LDB, hi));
            end
            next_cycle();
        end
        compare_bit("o_ld_valid", o_ld_valid, 1'b0);
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        logic [31:0] r2;
        lc3b_word    addr;
        i_rst_n       = 1'b0;
        i_op_valid    = 1'b0;
        i_op          = OP_LDR;
        i_addr        = '0;
        i_wdata       = '0;
        i_d_mem_resp  = 1'b0;
        i_d_mem_rdata = '0;
        i_event       = '0;
        for (i = 0; i < NUM_COUNTERS; i++) begin
            cnt_model[i] = '0;
        end
        for (i = 0; i < 32768; i++) begin
            mem_model[i] = lc3b_word'(i * 40503) ^ 16'h5A3C;
        end
        repeat (2) @(posedge clk);
        #2;
        i_rst_n = 1'b1;

        // Idle outputs and zero slots after reset
        compare_bit("o_d_mem_read", o_d_mem_read, 1'b0);
        compare_bit("o_d_mem_write", o_d_mem_write, 1'b0);
        compare_bit("o_stall_pipe", o_stall_pipe, 1'b0);
        compare_bit("o_ld_valid", o_ld_valid, 1'b0);
        for (i = 0; i < PERF_SLOTS; i++) begin
            window_op(OP_LDR, i, 1'b0, '0, '0);
        end

        // Random loads and stores outside the window with many on a small address pool
        for (i = 0; i < 80; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            addr = r[16] ? {10'h040, r[5:0]} : r[15:0];
            if (addr >= PERF_BASE) begin
                addr[8] = 1'b0;
            end
            mem_op(mem_op_t'(r[18:17]), addr, r2[15:0]);
        end

        // Event bursts, then counter reads with events still arriving
        run_events(200);
        for (i = 0; i < PERF_SLOTS; i++) begin
            window_op(OP_LDR, i, 1'b0, '0, '0);
        end
        for (i = 0; i < 40; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            window_op(r[4] ? OP_LDB : OP_LDR, int'(r[3:0]), r[4] & r[5], '0,
                      r2[NUM_COUNTERS-1:0]);
        end

        // Clear wins over a same-edge event
        for (i = 0; i < NUM_COUNTERS; i++) begin
            r = $random(seed);
            window_op(r[0] ? OP_STB : OP_STR, i, r[1], r[31:16], '1);
            run_events(15);
            window_op(OP_LDR, i, 1'b0, '0, '0);
        end

        // Store to an empty slot leaves every counter alone
        window_op(OP_STR, 12, 1'b0, 16'hBEEF, '1);
        for (i = 0; i < PERF_SLOTS; i++) begin
            window_op(OP_LDR, i, 1'b0, '0, '0);
        end

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
